// ==== source/tqv_isa_pkg.sv ====
// ISA package with ALU opcodes, CSR addresses and architectural constants
package tqv_isa_pkg;

    localparam int XLEN = 32;

    // misa reports RV32 with the C and E extensions
    localparam logic [XLEN-1:0] MISA_VALUE   = 32'h4000_0014;
    localparam logic [XLEN-1:0] MIMPID_VALUE = 32'd3;

    // Encoded as {funct7[5], funct3}
    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_SUB  = 4'b1000,
        ALU_SLT  = 4'b0010,
        ALU_SLTU = 4'b0011,
        ALU_XOR  = 4'b0100,
        ALU_OR   = 4'b0110,
        ALU_AND  = 4'b0111
    } alu_op_e;

    // Read-only CSRs served by the core
    typedef enum logic [11:0] {
        CSR_MISA     = 12'h301,
        CSR_MINSTRET = 12'hC02,
        CSR_MIMPID   = 12'hF13
    } csr_addr_e;

endpackage

// ==== source/tqv_uarch_pkg.sv ====
// Microarchitecture package with nibble, sub-cycle counter and pass types
package tqv_uarch_pkg;

    localparam int NIBBLE_W = 4;
    localparam int NIBBLES  = 8;  // Nibbles per 32-bit word

    typedef logic [NIBBLE_W-1:0] nibble_t;

    // One count per nibble of the word
    typedef logic [$clog2(NIBBLES)-1:0] count_t;

    localparam count_t LAST_COUNT = count_t'(NIBBLES - 1);

    // Compare instructions need a second pass to write back
    typedef enum logic {
        PASS_FIRST  = 1'b0,
        PASS_SECOND = 1'b1
    } pass_e;

endpackage

// ==== source/tqv_reg_if.sv ====
// Register port interface between control, ALU and register file
interface tqv_reg_if #(
    parameter int REG_ADDR_BITS = 4
) ();

    logic [REG_ADDR_BITS-1:0] rs1;
    logic [REG_ADDR_BITS-1:0] rs2;
    logic [REG_ADDR_BITS-1:0] rd;

    tqv_uarch_pkg::nibble_t data_rs1;
    tqv_uarch_pkg::nibble_t data_rs2;

    logic                   wr_en;
    tqv_uarch_pkg::nibble_t data_rd;

    modport regs (
        input  rs1, rs2, rd, wr_en, data_rd,
        output data_rs1, data_rs2
    );

    modport ctrl (output wr_en, data_rd);

    modport alu (input data_rs1, data_rs2);

endinterface

// ==== source/tqv_registers.sv ====
// Serial register file with nibble rotation and a hardwired zero register
module tqv_registers #(
    parameter int REG_ADDR_BITS = 4
) (
    input  logic                  clk,
    input  logic                  rstn,
    input  tqv_uarch_pkg::count_t counter,
    tqv_reg_if.regs               regs
);

    localparam int NUM_REGS = 2 ** REG_ADDR_BITS;
    localparam int XLEN     = tqv_isa_pkg::XLEN;
    localparam int NW       = tqv_uarch_pkg::NIBBLE_W;

    // x0 is not stored
    logic [XLEN-1:0] regs_q [1:NUM_REGS-1];

    // Every register shifts right one nibble per clock so nibble n is at the bottom on count n
    always_ff @(posedge clk) begin
        for (int i = 1; i < NUM_REGS; i++) begin
            if (regs.wr_en && regs.rd == REG_ADDR_BITS'(i)) begin
                regs_q[i] <= {regs.data_rd, regs_q[i][XLEN-1:NW]};
            end else begin
                regs_q[i] <= {regs_q[i][NW-1:0], regs_q[i][XLEN-1:NW]};
            end
        end
    end

    assign regs.data_rs1 = (regs.rs1 == '0) ? '0 : regs_q[regs.rs1][NW-1:0];
    assign regs.data_rs2 = (regs.rs2 == '0) ? '0 : regs_q[regs.rs2][NW-1:0];

    // A write pass must not hop between destination registers
    rd_stable_during_write: assert property (
        @(posedge clk) disable iff (!rstn)
        (regs.wr_en && counter != tqv_uarch_pkg::LAST_COUNT) |=> (!regs.wr_en || $stable(regs.rd))
    ) else $error("rd changed in the middle of a write pass");

endmodule

// ==== source/tqv_alu.sv ====
// Nibble ALU with carry chain, compare state and operand selection
module tqv_alu (
    input  logic                   clk,
    tqv_reg_if.alu                 alu,
    input  tqv_uarch_pkg::count_t  counter,
    input  tqv_isa_pkg::alu_op_e   alu_op,
    input  logic                   is_alu_imm,
    input  tqv_uarch_pkg::nibble_t imm,
    output tqv_uarch_pkg::nibble_t alu_out,
    output logic                   cmp
);

    localparam int NW = tqv_uarch_pkg::NIBBLE_W;

    tqv_uarch_pkg::nibble_t op_a;
    tqv_uarch_pkg::nibble_t op_b;
    tqv_uarch_pkg::nibble_t b_eff;
    logic                   is_sub;
    logic                   cy;
    logic                   cy_in;
    logic [NW:0]            sum;
    logic                   lt;

    assign op_a = alu.data_rs1;
    assign op_b = is_alu_imm ? imm : alu.data_rs2;

    assign is_sub = alu_op inside {tqv_isa_pkg::ALU_SUB, tqv_isa_pkg::ALU_SLT,
                                   tqv_isa_pkg::ALU_SLTU};

    // Subtract as a + ~b + 1, with the +1 preloaded into the carry at nibble 0
    assign cy_in = (counter == '0) ? is_sub : cy;
    assign b_eff = is_sub ? ~op_b : op_b;
    assign sum   = {1'b0, op_a} + {1'b0, b_eff} + (NW + 1)'(cy_in);

    always_comb begin
        case (alu_op)
            tqv_isa_pkg::ALU_XOR: alu_out = op_a ^ op_b;
            tqv_isa_pkg::ALU_OR:  alu_out = op_a | op_b;
            tqv_isa_pkg::ALU_AND: alu_out = op_a & op_b;
            default:              alu_out = sum[NW-1:0];
        endcase
    end

    // Only meaningful on the top nibble
    always_comb begin
        if (alu_op == tqv_isa_pkg::ALU_SLTU) begin
            lt = !sum[NW];                       // Borrow out of the top nibble
        end else if (op_a[NW-1] != op_b[NW-1]) begin
            lt = op_a[NW-1];                     // Signs differ, negative a is less
        end else begin
            lt = sum[NW-1];
        end
    end

    always_ff @(posedge clk) begin
        cy <= sum[NW];
        if (counter == tqv_uarch_pkg::LAST_COUNT) begin
            cmp <= lt;
        end
    end

    legal_alu_op: assert property (
        @(posedge clk) !$isunknown(alu_op) |-> alu_op inside {
            tqv_isa_pkg::ALU_ADD, tqv_isa_pkg::ALU_SUB, tqv_isa_pkg::ALU_SLT,
            tqv_isa_pkg::ALU_SLTU, tqv_isa_pkg::ALU_XOR, tqv_isa_pkg::ALU_OR,
            tqv_isa_pkg::ALU_AND}
    ) else $error("Illegal ALU opcode %b", alu_op);

endmodule

// ==== source/tqv_csr.sv ====
// Retired instruction counter and read-only CSR nibble multiplexer
module tqv_csr (
    input  logic                   clk,
    input  logic                   rstn,
    input  tqv_uarch_pkg::count_t  counter,
    input  tqv_isa_pkg::csr_addr_e csr_addr,
    input  logic                   retire,
    output tqv_uarch_pkg::nibble_t csr_nibble
);

    localparam int XLEN = tqv_isa_pkg::XLEN;
    localparam int NW   = tqv_uarch_pkg::NIBBLE_W;

    logic [XLEN-1:0] minstret;
    logic [XLEN-1:0] csr_word;

    // Bumps at the end of the completing clock, so the next pass reads a stable value
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            minstret <= '0;
        end else if (retire) begin
            minstret <= minstret + 1'b1;
        end
    end

    always_comb begin
        case (csr_addr)
            tqv_isa_pkg::CSR_MISA:     csr_word = tqv_isa_pkg::MISA_VALUE;
            tqv_isa_pkg::CSR_MIMPID:   csr_word = tqv_isa_pkg::MIMPID_VALUE;
            tqv_isa_pkg::CSR_MINSTRET: csr_word = minstret;
            default:                   csr_word = '0;  // Unimplemented CSRs read zero
        endcase
    end

    // Nibble n of the word on count n
    assign csr_nibble = csr_word[NW*counter +: NW];

endmodule

// ==== source/tqv_control.sv ====
// Sub-cycle counter, pass tracking, completion and writeback selection
module tqv_control (
    input  logic                   clk,
    input  logic                   rstn,
    tqv_reg_if.ctrl                ctrl,
    output tqv_uarch_pkg::count_t  counter,
    input  logic                   is_alu_imm,
    input  logic                   is_alu_reg,
    input  logic                   is_lui,
    input  logic                   is_csr,
    input  tqv_isa_pkg::alu_op_e   alu_op,
    input  tqv_uarch_pkg::nibble_t imm,
    input  tqv_uarch_pkg::nibble_t alu_out,
    input  logic                   cmp,
    input  tqv_uarch_pkg::nibble_t csr_nibble,
    output logic                   instr_complete,
    output logic                   retire
);

    tqv_uarch_pkg::pass_e pass;
    logic                 is_alu;
    logic                 is_cmp;
    logic                 last_count;

    assign last_count = (counter == tqv_uarch_pkg::LAST_COUNT);
    assign is_alu     = is_alu_imm || is_alu_reg;
    assign is_cmp     = is_alu && (alu_op inside {tqv_isa_pkg::ALU_SLT, tqv_isa_pkg::ALU_SLTU});

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            counter <= '0;
            pass    <= tqv_uarch_pkg::PASS_FIRST;
        end else begin
            counter <= counter + 1'b1;  // Free running, wraps after the top nibble
            if (last_count) begin
                pass <= instr_complete ? tqv_uarch_pkg::PASS_FIRST : tqv_uarch_pkg::PASS_SECOND;
            end
        end
    end

    // Compares need their result from the first pass before they can write
    assign instr_complete = last_count && (!is_cmp || pass == tqv_uarch_pkg::PASS_SECOND);
    assign retire         = instr_complete;

    always_comb begin
        ctrl.wr_en   = 1'b0;
        ctrl.data_rd = '0;
        if (is_cmp) begin
            ctrl.wr_en = (pass == tqv_uarch_pkg::PASS_SECOND);
            if (counter == '0) begin
                ctrl.data_rd = tqv_uarch_pkg::nibble_t'(cmp);
            end
        end else if (is_alu) begin
            ctrl.wr_en   = 1'b1;
            ctrl.data_rd = alu_out;
        end else if (is_lui) begin
            ctrl.wr_en   = 1'b1;
            ctrl.data_rd = imm;
        end else if (is_csr) begin
            ctrl.wr_en   = 1'b1;
            ctrl.data_rd = csr_nibble;
        end
    end

    // The instruction stays on the inputs until the clock that completes it
    instr_held_until_complete: assert property (
        @(posedge clk) disable iff (!rstn)
        !instr_complete |=> $stable({is_alu_imm, is_alu_reg, is_lui, is_csr, alu_op})
    ) else $error("Instruction changed before it completed");

endmodule

// ==== source/tqv_core.sv ====
// Top level of the nibble-serial execution core with plain ports
module tqv_core #(
    parameter int REG_ADDR_BITS = 4
) (
    input  logic                     clk,
    input  logic                     rstn,

    input  logic                     is_alu_imm,
    input  logic                     is_alu_reg,
    input  logic                     is_lui,
    input  logic                     is_csr,
    input  logic [3:0]               alu_op,     // {funct7[5], funct3}

    input  logic [REG_ADDR_BITS-1:0] rs1,
    input  logic [REG_ADDR_BITS-1:0] rs2,
    input  logic [REG_ADDR_BITS-1:0] rd,
    input  logic [3:0]               imm,        // Immediate nibble for the current count
    input  logic [11:0]              csr_addr,

    output logic [2:0]               counter,
    output logic                     instr_complete,

    output logic                     debug_reg_wen,
    output logic [3:0]               debug_rd
);

    tqv_isa_pkg::alu_op_e   alu_op_enum;
    tqv_isa_pkg::csr_addr_e csr_addr_enum;
    tqv_uarch_pkg::nibble_t alu_out;
    tqv_uarch_pkg::nibble_t csr_nibble;
    logic                   cmp;
    logic                   retire;

    assign alu_op_enum   = tqv_isa_pkg::alu_op_e'(alu_op);
    assign csr_addr_enum = tqv_isa_pkg::csr_addr_e'(csr_addr);

    tqv_reg_if #(.REG_ADDR_BITS(REG_ADDR_BITS)) reg_bus ();

    assign reg_bus.rs1 = rs1;
    assign reg_bus.rs2 = rs2;
    assign reg_bus.rd  = rd;

    tqv_registers #(.REG_ADDR_BITS(REG_ADDR_BITS)) i_registers (
        .clk     (clk),
        .rstn    (rstn),
        .counter (counter),
        .regs    (reg_bus)
    );

    tqv_alu i_alu (
        .clk        (clk),
        .alu        (reg_bus),
        .counter    (counter),
        .alu_op     (alu_op_enum),
        .is_alu_imm (is_alu_imm),
        .imm        (imm),
        .alu_out    (alu_out),
        .cmp        (cmp)
    );

    tqv_csr i_csr (
        .clk        (clk),
        .rstn       (rstn),
        .counter    (counter),
        .csr_addr   (csr_addr_enum),
        .retire     (retire),
        .csr_nibble (csr_nibble)
    );

    tqv_control i_control (
        .clk            (clk),
        .rstn           (rstn),
        .ctrl           (reg_bus),
        .counter        (counter),
        .is_alu_imm     (is_alu_imm),
        .is_alu_reg     (is_alu_reg),
        .is_lui         (is_lui),
        .is_csr         (is_csr),
        .alu_op         (alu_op_enum),
        .imm            (imm),
        .alu_out        (alu_out),
        .cmp            (cmp),
        .csr_nibble     (csr_nibble),
        .instr_complete (instr_complete),
        .retire         (retire)
    );

    // The writeback port is the only view of results
    assign debug_reg_wen = reg_bus.wr_en;
    assign debug_rd      = reg_bus.data_rd;

endmodule

// ==== verif/tqv_clkgen.sv ====
// Testbench clock and active-low reset generator
module tqv_clkgen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic rstn
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Released just after an edge, like the rest of the stimulus
    initial begin
        rstn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rstn = 1'b1;
    end

endmodule

// ==== verif/tqv_core_tb.sv ====
// Testbench for tqv_core with stimulus, reference model, result checker and reporting
module tqv_core_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int KIND_ALU_REG = 0;
    localparam int KIND_ALU_IMM = 1;
    localparam int KIND_LUI     = 2;
    localparam int KIND_CSR     = 3;
    localparam int TIMEOUT_CLKS = 40;

    logic        clk;
    logic        rstn;
    logic        is_alu_imm;
    logic        is_alu_reg;
    logic        is_lui;
    logic        is_csr;
    logic [3:0]  alu_op;
    logic [3:0]  rs1;
    logic [3:0]  rs2;
    logic [3:0]  rd;
    logic [3:0]  imm;
    logic [11:0] csr_addr;
    logic [2:0]  counter;
    logic        instr_complete;
    logic        debug_reg_wen;
    logic [3:0]  debug_rd;

    logic [31:0] model_regs [16];
    int          model_retired;
    logic [31:0] lcg_state;
    logic [31:0] expected_q [$];
    string       name_q [$];
    string       test_name;
    int          test_instrs;
    int          test_errors;
    int          tests_run;
    int          tests_failed;
    int          check_count;
    int          error_count;
    bit          aborted;
    logic [31:0] got_word;       // Nibbles seen on the write port
    int          wen_cycles;
    logic [31:0] next_expected;
    string       next_name;

    tqv_clkgen clkgen (.clk(clk), .rstn(rstn));

    tqv_core #(.REG_ADDR_BITS(4)) DUT (.*);

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state ^ {16'd0, lcg_state[31:16]};  // Fold high bits into the weak low ones
    endfunction

    function automatic logic [3:0] random_reg();
        logic [31:0] r;
        r = next_random();
        return r[3:0];
    endfunction

    function automatic logic [3:0] random_dest();
        logic [31:0] r;
        r = next_random();
        return (r[3:0] == 4'd0) ? 4'd15 : r[3:0];
    endfunction

    function automatic tqv_isa_pkg::alu_op_e pick_op(input logic [31:0] r);
        case (r[2:0])
            3'd0, 3'd5: return tqv_isa_pkg::ALU_ADD;
            3'd1, 3'd6: return tqv_isa_pkg::ALU_SUB;
            3'd2:       return tqv_isa_pkg::ALU_XOR;
            3'd3:       return tqv_isa_pkg::ALU_OR;
            default:    return tqv_isa_pkg::ALU_AND;
        endcase
    endfunction

    // Expected 32-bit writeback value from the model state
    function automatic logic [31:0] reference_result(input int kind,
            input tqv_isa_pkg::alu_op_e op, input logic [3:0] r1, input logic [3:0] r2,
            input logic [31:0] imm_val, input logic [11:0] csr);
        logic [31:0] a;
        logic [31:0] b;
        a = model_regs[r1];
        b = (kind == KIND_ALU_IMM) ? imm_val : model_regs[r2];
        if (kind == KIND_LUI) begin
            return imm_val;
        end else if (kind == KIND_CSR) begin
            case (csr)
                tqv_isa_pkg::CSR_MISA:     return 32'h4000_0014;
                tqv_isa_pkg::CSR_MIMPID:   return 32'd3;
                tqv_isa_pkg::CSR_MINSTRET: return 32'(model_retired);
                default:                   return 32'd0;
            endcase
        end
        case (op)
            tqv_isa_pkg::ALU_ADD:  return a + b;
            tqv_isa_pkg::ALU_SUB:  return a - b;
            tqv_isa_pkg::ALU_SLT:  return {31'd0, $signed(a) < $signed(b)};
            tqv_isa_pkg::ALU_SLTU: return {31'd0, a < b};
            tqv_isa_pkg::ALU_XOR:  return a ^ b;
            tqv_isa_pkg::ALU_OR:   return a | b;
            default:               return a & b;
        endcase
    endfunction

    task automatic compare_values(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            test_errors++;
            $display("ERR %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_instrs = 0;
        test_errors = 0;
    endtask

    task automatic finish_test();
        tests_run++;
        if (test_errors > 0 || aborted) begin
            tests_failed++;
        end
        if (aborted) begin
            $display("%s: stopped by a timeout", test_name);
        end else begin
            $display("%s: %0d instructions, %0d mismatches", test_name, test_instrs, test_errors);
        end
    endtask

    // Leaves the driver 1 ns after the edge that brings counter back to 0
    task automatic sync_after_reset();
        int waited;
        waited = 0;
        @(negedge clk);
        while (!rstn && waited < TIMEOUT_CLKS) begin
            @(negedge clk);
            waited++;
        end
        if (!rstn) begin
            $display("Reset was never released");
            aborted = 1'b1;
            return;
        end
        compare_values("reset counter", 32'd0, 32'(counter));
        compare_values("reset instr_complete", 32'd0, 32'(instr_complete));
        compare_values("reset debug_reg_wen", 32'd0, 32'(debug_reg_wen));
        waited = 0;
        while (counter != 3'd7 && waited < TIMEOUT_CLKS) begin
            @(negedge clk);
            waited++;
        end
        if (counter != 3'd7) begin
            $display("Counter never reached its last nibble after reset");
            aborted = 1'b1;
            return;
        end
        model_retired = 1;  // Idle pass retires as a no-op
        @(posedge clk);
        #1;
    endtask

    // Presents one instruction at count 0 and holds it until completion
    task automatic execute(input int kind, input tqv_isa_pkg::alu_op_e op, input logic [3:0] r1,
                           input logic [3:0] r2, input logic [3:0] d, input logic [31:0] imm_val,
                           input logic [11:0] csr);
        logic [31:0] expected;
        int          waited;
        int          nib;
        if (aborted) return;
        expected = reference_result(kind, op, r1, r2, imm_val, csr);
        expected_q.push_back(expected);
        name_q.push_back($sformatf("%s #%0d", test_name, test_instrs));
        is_alu_reg = (kind == KIND_ALU_REG);
        is_alu_imm = (kind == KIND_ALU_IMM);
        is_lui     = (kind == KIND_LUI);
        is_csr     = (kind == KIND_CSR);
        alu_op     = op;
        rs1        = r1;
        rs2        = r2;
        rd         = d;
        csr_addr   = csr;
        imm        = imm_val[3:0];
        nib        = 0;
        waited     = 0;
        @(negedge clk);
        while (!instr_complete && waited < TIMEOUT_CLKS) begin
            @(posedge clk);
            #1;
            nib = (nib + 1) % 8;
            imm = imm_val[4*nib +: 4];  // Streamed immediate follows the counter
            @(negedge clk);
            waited++;
        end
        if (!instr_complete) begin
            $display("%s #%0d did not complete within %0d clocks", test_name, test_instrs,
                     TIMEOUT_CLKS);
            aborted = 1'b1;
            return;
        end
        if (d != 4'd0) begin
            model_regs[d] = expected;
        end
        model_retired++;
        test_instrs++;
        @(posedge clk);
        #1;
    endtask

    // Collects the written nibbles and checks each instruction as it completes
    always @(negedge clk) begin
        if (rstn) begin
            if (debug_reg_wen) begin
                got_word[4*counter +: 4] = debug_rd;
                wen_cycles++;
            end
            if (instr_complete) begin
                if (expected_q.size() > 0) begin
                    next_expected = expected_q.pop_front();
                    next_name     = name_q.pop_front();
                    compare_values({next_name, " result"}, next_expected, got_word);
                    compare_values({next_name, " write cycles"}, 32'd8, 32'(wen_cycles));
                    compare_values({next_name, " complete count"}, 32'd7, 32'(counter));
                end
                got_word   = '0;
                wen_cycles = 0;
            end
        end
    end

    initial begin
        logic [31:0]           r;
        logic [3:0]            s1;
        logic [3:0]            s2;
        logic [3:0]            dst;
        tqv_isa_pkg::alu_op_e  op;
        is_alu_imm    = 1'b0;
        is_alu_reg    = 1'b0;
        is_lui        = 1'b0;
        is_csr        = 1'b0;
        alu_op        = 4'd0;
        rs1           = 4'd0;
        rs2           = 4'd0;
        rd            = 4'd0;
        imm           = 4'd0;
        csr_addr      = 12'd0;
        lcg_state     = 32'hdf0b2beb;
        model_retired = 0;
        tests_run     = 0;
        tests_failed  = 0;
        check_count   = 0;
        error_count   = 0;
        aborted       = 1'b0;
        got_word      = '0;
        wen_cycles    = 0;
        foreach (model_regs[i])
            model_regs[i] = '0;

        start_test("reset");
        sync_after_reset();
        finish_test();

        start_test("lui_seed");
        for (int i = 1; i < 16; i++) begin
            execute(KIND_LUI, tqv_isa_pkg::ALU_ADD, 4'd0, 4'd0, 4'(i), next_random(), 12'd0);
        end
        finish_test();

        start_test("alu_reg");
        for (int i = 0; i < 40; i++) begin
            op  = pick_op(next_random());
            s1  = random_reg();
            s2  = random_reg();
            dst = random_dest();
            execute(KIND_ALU_REG, op, s1, s2, dst, 32'd0, 12'd0);
        end
        finish_test();

        start_test("alu_imm");
        for (int i = 0; i < 40; i++) begin
            op  = pick_op(next_random());
            s1  = random_reg();
            dst = random_dest();
            execute(KIND_ALU_IMM, op, s1, 4'd0, dst, next_random(), 12'd0);
        end
        finish_test();

        // x1 negative, x2 small positive
        start_test("compare");
        execute(KIND_LUI, tqv_isa_pkg::ALU_ADD, 4'd0, 4'd0, 4'd1, 32'h8000_0005, 12'd0);
        execute(KIND_LUI, tqv_isa_pkg::ALU_ADD, 4'd0, 4'd0, 4'd2, 32'h0000_0007, 12'd0);
        execute(KIND_ALU_REG, tqv_isa_pkg::ALU_SLT, 4'd1, 4'd2, 4'd3, 32'd0, 12'd0);
        execute(KIND_ALU_REG, tqv_isa_pkg::ALU_SLTU, 4'd1, 4'd2, 4'd4, 32'd0, 12'd0);
        execute(KIND_ALU_REG, tqv_isa_pkg::ALU_SLT, 4'd2, 4'd1, 4'd5, 32'd0, 12'd0);
        execute(KIND_ALU_REG, tqv_isa_pkg::ALU_SLTU, 4'd2, 4'd1, 4'd6, 32'd0, 12'd0);
        execute(KIND_ALU_REG, tqv_isa_pkg::ALU_SLT, 4'd1, 4'd1, 4'd7, 32'd0, 12'd0);
        execute(KIND_ALU_REG, tqv_isa_pkg::ALU_SLTU, 4'd2, 4'd2, 4'd8, 32'd0, 12'd0);
        execute(KIND_ALU_IMM, tqv_isa_pkg::ALU_SLT, 4'd1, 4'd0, 4'd9, 32'hffff_ffff, 12'd0);
        execute(KIND_ALU_IMM, tqv_isa_pkg::ALU_SLTU, 4'd2, 4'd0, 4'd10, 32'd7, 12'd0);
        for (int i = 0; i < 16; i++) begin
            r   = next_random();
            op  = r[0] ? tqv_isa_pkg::ALU_SLT : tqv_isa_pkg::ALU_SLTU;
            s1  = random_reg();
            s2  = random_reg();
            dst = random_dest();
            execute(r[1] ? KIND_ALU_IMM : KIND_ALU_REG, op, s1, s2, dst, next_random(), 12'd0);
        end
        finish_test();

        start_test("zero_reg");
        execute(KIND_LUI, tqv_isa_pkg::ALU_ADD, 4'd0, 4'd0, 4'd0, 32'hdead_beef, 12'd0);
        execute(KIND_ALU_REG, tqv_isa_pkg::ALU_ADD, 4'd0, 4'd0, 4'd11, 32'd0, 12'd0);
        execute(KIND_ALU_REG, tqv_isa_pkg::ALU_OR, 4'd0, 4'd1, 4'd12, 32'd0, 12'd0);
        finish_test();

        start_test("csr_read");
        execute(KIND_CSR, tqv_isa_pkg::ALU_ADD, 4'd0, 4'd0, 4'd13, 32'd0, tqv_isa_pkg::CSR_MISA);
        execute(KIND_CSR, tqv_isa_pkg::ALU_ADD, 4'd0, 4'd0, 4'd14, 32'd0, tqv_isa_pkg::CSR_MIMPID);
        execute(KIND_CSR, tqv_isa_pkg::ALU_ADD, 4'd0, 4'd0, 4'd15, 32'd0,
                tqv_isa_pkg::CSR_MINSTRET);
        execute(KIND_CSR, tqv_isa_pkg::ALU_ADD, 4'd0, 4'd0, 4'd13, 32'd0, 12'h300);  // Unknown
        execute(KIND_CSR, tqv_isa_pkg::ALU_ADD, 4'd0, 4'd0, 4'd14, 32'd0,
                tqv_isa_pkg::CSR_MINSTRET);
        finish_test();

        if (aborted) begin
            $display("Run stopped early after a timeout");
        end
        $display("Tests %0d, failing tests %0d, checks %0d, mismatches %0d", tests_run,
                 tests_failed, check_count, error_count);
        if (!aborted && error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== tinyqv_lite.f ====
source/tqv_isa_pkg.sv
source/tqv_uarch_pkg.sv
source/tqv_reg_if.sv
source/tqv_registers.sv
source/tqv_alu.sv
source/tqv_csr.sv
source/tqv_control.sv
source/tqv_core.sv
verif/tqv_clkgen.sv
verif/tqv_core_tb.sv

// ==== Makefile ====
# Verilator flow for the nibble-serial core

SIM       := verilator
TOP       := tqv_core_tb
FILELIST  := tinyqv_lite.f
BUILD_DIR := obj_dir
LOG       := sim.log
FLAGS     := --timing --assert --timescale 1ns/1ps
PASS_MSG  := Testbench passed

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# The status of the last command is the status of the target
sim:
	$(SIM) --binary -j 0 $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG); grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
